/* hdl/ldpcCodePkg.sv */
// ========================================
// (1280,1024) QC-LDPC code constants
// generator rows are written lane 0 word first,
// lane 7 word last, one 256-bit row per block
// ========================================
`default_nettype none

package ldpcCodePkg;

  localparam int CODE_N      = 1280;
  localparam int CODE_K      = 1024;
  localparam int PARITY_BITS = CODE_N - CODE_K;
  localparam int CIRC_SIZE   = 32;
  localparam int NUM_LANES   = PARITY_BITS / CIRC_SIZE;
  localparam int NUM_BLOCKS  = CODE_K / CIRC_SIZE;

  // first row of every information row block
  localparam logic [PARITY_BITS-1:0] GEN_ROWS [NUM_BLOCKS] = '{
    256'h678ECB51_FE821D5C_FA5F424B_F55927AA_3E826913_32E04B0C_4F88862B_803432EF,
    256'h42B27625_9F8DA1E1_F8472D1B_D943D394_29261575_BA434C68_18EF349A_27CA1CC4,
    256'hEC900397_64A4A063_9BCEC4A6_D05BA70F_E7155BE1_7FF09CC1_6E2E2059_7F1567E5,
    256'h5616101C_EA060E2B_8C0A2F64_923BDF8B_B9B9343D_049C63A8_333E9CFE_809B362D,
    256'h9D41634C_404E17DA_3B4161F2_5235992E_EA4B4B8B_4690BCE1_F9DA36A1_16439BB1,
    256'h5D7254B5_15B4978B_00D05224_107BD904_C85D7E58_0451F1A5_EE9D1897_913DA6F9,
    256'h42819F61_343773CA_11A6492A_4832F43F_849C11ED_F0FE864F_CC270400_9726D66E,
    256'h89EE2A44_685C1F67_1DF6E416_507BF2EF_8759C2FB_52162ABF_2B61D3FB_988708C4,
    256'h4A8FEA09_53452354_A33E2E73_271E8211_16DF62E5_03DF81F4_8848BD0F_F95DF357,
    256'h9BE0A7B3_617256EB_9A4D0BB4_FE3A3A19_FAA63D9E_65328918_D699BA35_4CDE6FE0,
    256'h848B1FE5_0AB58A6F_341707F1_EF36474B_F623A7A5_A35EC9BA_24909B6E_64A7A898,
    256'hBDDF3BAE_7202FA26_86F90C57_A0399F20_972B9A31_87B245AE_E0C5A338_4959AAD9,
    256'hCF726C27_7B38429A_BA37C244_EE7717DB_E45C99CA_7E3E013B_7B800CA4_6527F2E7,
    256'h75C63782_1CC40137_51E69F16_414B155F_DF1964DE_F13C71F7_6E9E8044_6C5CEC86,
    256'h6F2A6DF8_9FF2BF82_D3625355_24466981_D5F14AC1_E1C24AEA_A8850D83_7A3C5120,
    256'hBAABADC3_1ECF066D_76538348_FC5D4D54_43AD46CF_3342012C_63EBE2DC_D832EF8E,
    256'hE6EC82F1_4AAFE782_14D89E38_23C83402_8B48D6BF_C823B89A_68A35626_E89FE121,
    256'h4BBAA331_20EC16C9_6ADABE06_D803DA6D_FCC89D41_E57B10E8_CC3FF014_4DB74206,
    256'h503FD586_52F68B91_97D69DF3_129C764E_8B2143F7_A36EF3BA_7C27896C_560F67B5,
    256'hD70390E6_98B337EA_89568363_2A1681DF_4B4E928C_41EC3D9C_DFD92EB2_A5D5C85C,
    256'h2A5088BD_76CB6810_CB693D21_C0E9EFD5_F992506E_299CE082_901155A6_0B93AA16,
    256'h18FEFECE_B0063536_95487089_4BB31BB9_66F3FD97_E32B58A0_2A39427A_5CD8DE9F,
    256'h1A8F8616_C5F7D2B2_5AD2BC4E_BF1E86DB_ACF7BFFA_F3589597_3D6B1E87_12DD1364,
    256'hFFC03A59_DC450527_33B4C871_BAA2EA33_93A751A6_F9D72E4D_69B50C7F_F74151F9,
    256'h7BE8519D_AF6FFAFA_268DBA73_C2E57A19_0418BE2C_1A43465A_60C6DF65_0E2438A0,
    256'hEC25DC05_66AEE4A8_A72A030A_B11FB610_DD74DAF7_62F6D565_554EAEB7_15F7AE6C,
    256'h5147F90A_FF0EEC01_12A9966C_871705B1_E935FF30_46E32957_546D69FC_B8A1BD06,
    256'h6A80EA6F_71A29506_EF78AACF_8D52B5ED_9F0A4966_61B3B68E_4B17AF96_5B282C2E,
    256'h75582272_16E54299_7D070B9C_AB130157_76C619D2_5500E2D5_1F980459_5D9C7F83,
    256'h6A0DDA1D_F6E8B610_25D0E0A1_242749E0_FEDA4A06_072D69D6_03C7DA79_51AA3355,
    256'h6E9FEFF0_0797CBF1_E936C824_C9C1EAF5_D4607E46_88ED7B0E_92E160AD_731140AD,
    256'h32FEFCAF_70863B75_3846F110_C4E23DFF_79D3F753_064648FA_830452F5_B9ED8445
  };

  typedef logic [CIRC_SIZE-1:0] circWord_t;

  // word 0 sits in the most significant bits of the flat view
  typedef union packed {
    logic [PARITY_BITS-1:0]      flat;
    circWord_t [0:NUM_LANES-1]   words;
  } genRow_t;

endpackage

`default_nettype wire

/* hdl/ldpcFramePkg.sv */
// ========================================
// frame counter widths and beat limits
// one information or parity bit per beat
// ========================================
`default_nettype none

package ldpcFramePkg;

  localparam int BIT_CNT_W  = 10;
  localparam int BLOCK_W    = 5;
  localparam int PAR_CNT_W  = 8;
  localparam int LANE_IDX_W = 3;

  // index of the final information bit and of the final parity beat
  localparam logic [BIT_CNT_W-1:0] LAST_INFO_BIT = 10'd1023;
  localparam logic [PAR_CNT_W-1:0] LAST_PAR_BEAT = 8'd255;

endpackage

`default_nettype wire

/* hdl/encStepIf.sv */
// ========================================
// one encoding step, sequencer to lanes
// all fields valid only while step is high,
// clear stands alone
// ========================================
`default_nettype none

interface encStepIf;

  logic                             step;
  logic                             infoBit;
  logic                             blockEnd;
  logic [ldpcFramePkg::BLOCK_W-1:0] nextBlock;
  logic                             clear;

  modport seq (
    output step, infoBit, blockEnd, nextBlock, clear
  );

  modport lane (
    input step, infoBit, blockEnd, nextBlock, clear
  );

endinterface

`default_nettype wire

/* hdl/ldpcInputSequencer.sv */
// ========================================
// input side of the encoder
// input closes after bit 1023 and opens
// again only on frameDone
// ========================================
`default_nettype none

module ldpcInputSequencer (
  input  logic clk,
  input  logic rst_n,
  input  logic sAxisTdata,
  input  logic sAxisTvalid,
  output logic sAxisTready,
  encStepIf.seq stepBus,
  output logic infoValid,
  output logic infoBit,
  output logic infoLast,
  input  logic infoReady,
  input  logic frameDone
);

  logic                               armed;
  logic                               full;
  logic                               accept;
  logic [ldpcFramePkg::BIT_CNT_W-1:0] bitCnt;

  // held low for the first cycle out of reset
  assign sAxisTready = armed && !full && infoReady;
  assign accept      = sAxisTvalid && sAxisTready;

  assign infoValid = sAxisTvalid && armed && !full;
  assign infoBit   = sAxisTdata;
  assign infoLast  = (bitCnt == ldpcFramePkg::LAST_INFO_BIT);

  assign stepBus.step     = accept;
  assign stepBus.infoBit  = sAxisTdata;
  // low bits are the offset inside the row block
  assign stepBus.blockEnd =
    &bitCnt[ldpcFramePkg::BIT_CNT_W-ldpcFramePkg::BLOCK_W-1:0];
  assign stepBus.nextBlock =
    bitCnt[ldpcFramePkg::BIT_CNT_W-1 -: ldpcFramePkg::BLOCK_W] + 1'b1;
  assign stepBus.clear    = frameDone;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      armed  <= 1'b0;
      full   <= 1'b0;
      bitCnt <= '0;
    end
    else
    begin
      armed <= 1'b1;
      if (frameDone)
      begin
        full   <= 1'b0;
        bitCnt <= '0;
      end
      else if (accept)
      begin
        bitCnt <= bitCnt + 1'b1;
        if (infoLast)
        begin
          full <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ldpcParityLane.sv */
// ========================================
// one 32-bit circulant parity lane
// word rotates right once per step and
// reloads from the table at block ends
// ========================================
`default_nettype none

module ldpcParityLane #(
  parameter logic [ldpcFramePkg::LANE_IDX_W-1:0] LANE = '0
) (
  input  logic clk,
  input  logic rst_n,
  encStepIf.lane stepBus,
  output logic [ldpcCodePkg::CIRC_SIZE-1:0] parity
);

  ldpcCodePkg::genRow_t   firstRow;
  ldpcCodePkg::genRow_t   nextRow;
  ldpcCodePkg::circWord_t genWord;

  assign firstRow.flat = ldpcCodePkg::GEN_ROWS[0];
  assign nextRow.flat  = ldpcCodePkg::GEN_ROWS[stepBus.nextBlock];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      genWord <= firstRow.words[LANE];
      parity  <= '0;
    end
    else if (stepBus.clear)
    begin
      genWord <= firstRow.words[LANE];
      parity  <= '0;
    end
    else if (stepBus.step)
    begin
      if (stepBus.infoBit)
      begin
        parity <= parity ^ genWord;
      end
      if (stepBus.blockEnd)
      begin
        genWord <= nextRow.words[LANE];
      end
      else
      begin
        genWord <= {genWord[0], genWord[ldpcCodePkg::CIRC_SIZE-1:1]};
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ldpcOutputStage.sv */
// ========================================
// one-entry output register
// info bits pass through, then 256 parity
// bits go out MSB first, tlast on the last
// ========================================
`default_nettype none

module ldpcOutputStage (
  input  logic clk,
  input  logic rst_n,
  input  logic infoValid,
  input  logic infoBit,
  input  logic infoLast,
  output logic infoReady,
  input  logic [ldpcCodePkg::CIRC_SIZE-1:0] laneParity [ldpcCodePkg::NUM_LANES],
  output logic frameDone,
  output logic mAxisTdata,
  output logic mAxisTvalid,
  output logic mAxisTlast,
  input  logic mAxisTready
);

  ldpcCodePkg::genRow_t                 snap;
  logic [ldpcCodePkg::PARITY_BITS-1:0]  parShift;
  logic [ldpcFramePkg::PAR_CNT_W-1:0]   parCnt;
  logic                                 parPhase;
  logic                                 heldLast;
  logic                                 beatDone;
  logic                                 infoAccept;

  always_comb
  begin
    for (int i = 0; i < ldpcCodePkg::NUM_LANES; i++)
    begin
      snap.words[i] = laneParity[i];
    end
  end

  assign beatDone   = mAxisTvalid && mAxisTready;
  assign infoReady  = !parPhase && (!mAxisTvalid || mAxisTready);
  assign infoAccept = infoValid && infoReady;
  assign frameDone  = parPhase && mAxisTlast && beatDone;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mAxisTvalid <= 1'b0;
      mAxisTlast  <= 1'b0;
      parPhase    <= 1'b0;
      heldLast    <= 1'b0;
      parCnt      <= '0;
    end
    else if (parPhase)
    begin
      if (beatDone && mAxisTlast)
      begin
        parPhase    <= 1'b0;
        mAxisTvalid <= 1'b0;
        mAxisTlast  <= 1'b0;
      end
      else if (beatDone)
      begin
        parCnt     <= parCnt + 1'b1;
        mAxisTlast <= (parCnt == ldpcFramePkg::LAST_PAR_BEAT - 1'b1);
      end
    end
    else if (infoAccept)
    begin
      mAxisTvalid <= 1'b1;
      heldLast    <= infoLast;
    end
    else if (beatDone)
    begin
      // last info bit gone, parity follows without a gap
      if (heldLast)
      begin
        parPhase <= 1'b1;
        heldLast <= 1'b0;
        parCnt   <= '0;
      end
      else
      begin
        mAxisTvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (parPhase)
    begin
      if (beatDone && !mAxisTlast)
      begin
        mAxisTdata <= parShift[ldpcCodePkg::PARITY_BITS-1];
        parShift   <= {parShift[ldpcCodePkg::PARITY_BITS-2:0], 1'b0};
      end
    end
    else if (infoAccept)
    begin
      mAxisTdata <= infoBit;
    end
    else if (beatDone && heldLast)
    begin
      mAxisTdata <= snap.flat[ldpcCodePkg::PARITY_BITS-1];
      parShift   <= {snap.flat[ldpcCodePkg::PARITY_BITS-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* hdl/ldpcEncoder.sv */
// ========================================
// CCSDS (1280,1024) LDPC encoder top
// bit-serial AXI-Stream in and out,
// systematic order, tlast on beat 1280
// ========================================
`default_nettype none

module ldpcEncoder (
  input  logic clk,
  input  logic rst_n,
  input  logic sAxisTdata,
  input  logic sAxisTvalid,
  output logic sAxisTready,
  output logic mAxisTdata,
  output logic mAxisTvalid,
  output logic mAxisTlast,
  input  logic mAxisTready
);

  logic                             infoValid;
  logic                             infoBit;
  logic                             infoLast;
  logic                             infoReady;
  logic                             frameDone;
  logic [ldpcCodePkg::CIRC_SIZE-1:0] laneParity [ldpcCodePkg::NUM_LANES];

  encStepIf stepBus ();

  ldpcInputSequencer inputSeq (
    .clk         (clk),
    .rst_n       (rst_n),
    .sAxisTdata  (sAxisTdata),
    .sAxisTvalid (sAxisTvalid),
    .sAxisTready (sAxisTready),
    .stepBus     (stepBus.seq),
    .infoValid   (infoValid),
    .infoBit     (infoBit),
    .infoLast    (infoLast),
    .infoReady   (infoReady),
    .frameDone   (frameDone)
  );

  for (genvar laneIdx = 0; laneIdx < ldpcCodePkg::NUM_LANES; laneIdx++)
  begin : laneGen
    ldpcParityLane #(
      .LANE (ldpcFramePkg::LANE_IDX_W'(laneIdx))
    ) parityLane (
      .clk     (clk),
      .rst_n   (rst_n),
      .stepBus (stepBus.lane),
      .parity  (laneParity[laneIdx])
    );
  end

  ldpcOutputStage outStage (
    .clk         (clk),
    .rst_n       (rst_n),
    .infoValid   (infoValid),
    .infoBit     (infoBit),
    .infoLast    (infoLast),
    .infoReady   (infoReady),
    .laneParity  (laneParity),
    .frameDone   (frameDone),
    .mAxisTdata  (mAxisTdata),
    .mAxisTvalid (mAxisTvalid),
    .mAxisTlast  (mAxisTlast),
    .mAxisTready (mAxisTready)
  );

endmodule

`default_nettype wire

/* bench/ldpcEncoder_checker.sv */
// ========================================
// stream protocol checks for the encoder
// bound into the top level; failCnt counts
// assertion failures for the testbench
// ========================================
`default_nettype none

module ldpcEncoder_checker (
  input logic clk,
  input logic rst_n,
  input logic sAxisTdata,
  input logic sAxisTvalid,
  input logic sAxisTready,
  input logic mAxisTdata,
  input logic mAxisTvalid,
  input logic mAxisTlast,
  input logic mAxisTready
);

  timeunit 1ns;
  timeprecision 1ps;

  int          failCnt = 0;
  logic [10:0] outCnt;
  logic        parActive;

  // output beat position inside the codeword
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      outCnt <= '0;
    end
    else if (mAxisTvalid && mAxisTready)
    begin
      outCnt <= mAxisTlast ? '0 : outCnt + 11'd1;
    end
  end

  assign parActive = (int'(outCnt) >= ldpcCodePkg::CODE_K);

  sInputHeld: assert property (@(posedge clk) disable iff (!rst_n)
    sAxisTvalid && !sAxisTready |=> sAxisTvalid && $stable(sAxisTdata))
  else
  begin
    failCnt++;
    $error("input beat changed while stalled");
  end

  mOutputHeld: assert property (@(posedge clk) disable iff (!rst_n)
    mAxisTvalid && !mAxisTready |=>
      mAxisTvalid && $stable(mAxisTdata) && $stable(mAxisTlast))
  else
  begin
    failCnt++;
    $error("output beat changed while stalled");
  end

  noInputInParity: assert property (@(posedge clk) disable iff (!rst_n)
    parActive |-> !sAxisTready)
  else
  begin
    failCnt++;
    $error("input ready during parity phase");
  end

  lastWithValid: assert property (@(posedge clk) disable iff (!rst_n)
    mAxisTlast |-> mAxisTvalid)
  else
  begin
    failCnt++;
    $error("tlast high without tvalid");
  end

endmodule

`default_nettype wire

/* bench/ldpcEncoder_tb.sv */
// ========================================
// testbench for the LDPC encoder
// parity reference follows the circulant
// rule; protocol checks live in the checker
// ========================================
`default_nettype none

module ldpcEncoder_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int K     = ldpcCodePkg::CODE_K;
  localparam int N     = ldpcCodePkg::CODE_N;
  localparam int P     = ldpcCodePkg::PARITY_BITS;
  localparam int W     = ldpcCodePkg::CIRC_SIZE;
  localparam int L     = ldpcCodePkg::NUM_LANES;
  localparam int LIMIT = 4000;

  logic clk;
  logic rst_n;
  logic sAxisTdata;
  logic sAxisTvalid;
  logic sAxisTready;
  logic mAxisTdata;
  logic mAxisTvalid;
  logic mAxisTlast;
  logic mAxisTready = 1'b0;

  logic         expQ [$];
  logic         expBit;
  logic [K-1:0] frames [3];
  logic [K-1:0] oneHot;
  int           pos;
  int           outBeat = 0;
  int           inCnt = 0;
  bit           inClosed = 1'b0;
  int           monErr = 0;
  int           errCnt;
  int           testErr;
  int           testsRun;
  int           testsBad;
  bit           stallOut;
  bit           hung;

  ldpcEncoder dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .sAxisTdata  (sAxisTdata),
    .sAxisTvalid (sAxisTvalid),
    .sAxisTready (sAxisTready),
    .mAxisTdata  (mAxisTdata),
    .mAxisTvalid (mAxisTvalid),
    .mAxisTlast  (mAxisTlast),
    .mAxisTready (mAxisTready)
  );

  bind ldpcEncoder ldpcEncoder_checker checker0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .sAxisTdata  (sAxisTdata),
    .sAxisTvalid (sAxisTvalid),
    .sAxisTready (sAxisTready),
    .mAxisTdata  (mAxisTdata),
    .mAxisTvalid (mAxisTvalid),
    .mAxisTlast  (mAxisTlast),
    .mAxisTready (mAxisTready)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic bit bitMatches(input string name, input logic expv, input logic got);
    bit ok;
    ok = 1'b1;
    assert (got === expv) else
    begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expv, got);
      ok = 1'b0;
    end
    return ok;
  endfunction

  // bit i of block i/32 uses each lane word rotated right by i%32
  function automatic logic [P-1:0] refParity(input logic [K-1:0] info);
    logic [P-1:0]   par;
    logic [P-1:0]   row;
    logic [2*W-1:0] twice;
    par = '0;
    for (int i = 0; i < K; i++)
    begin
      if (info[i])
      begin
        row = ldpcCodePkg::GEN_ROWS[i / W];
        for (int l = 0; l < L; l++)
        begin
          twice = {2{row[P-1-W*l -: W]}} >> (i % W);
          par[P-1-W*l -: W] ^= twice[W-1:0];
        end
      end
    end
    return par;
  endfunction

  task automatic expectFrame(input logic [K-1:0] info);
    logic [P-1:0] par;
    par = refParity(info);
    for (int i = 0; i < K; i++)
    begin
      expQ.push_back(info[i]);
    end
    for (int b = P - 1; b >= 0; b--)
    begin
      expQ.push_back(par[b]);
    end
  endtask

  task automatic sendFrame(input logic [K-1:0] info, input bit gaps);
    int idx;
    int idle;
    idx = 0;
    idle = 0;
    while (idx < K && !hung)
    begin
      @(posedge clk);
      if (sAxisTvalid && sAxisTready)
      begin
        idx++;
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > LIMIT)
        begin
          $display("timeout: input bit %0d was never accepted", idx);
          hung = 1'b1;
        end
      end
      if (idx >= K || hung)
      begin
        sAxisTvalid <= 1'b0;
      end
      else if (!sAxisTvalid || sAxisTready)
      begin
        sAxisTvalid <= !gaps || ($urandom_range(3) != 0);
        sAxisTdata  <= info[idx];
      end
    end
  endtask

  task automatic drainOutput();
    int idle;
    int lastSize;
    idle = 0;
    lastSize = expQ.size();
    while (expQ.size() > 0 && !hung)
    begin
      @(posedge clk);
      if (expQ.size() != lastSize)
      begin
        lastSize = expQ.size();
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > LIMIT)
        begin
          $display("timeout: %0d output beats never arrived", expQ.size());
          hung = 1'b1;
        end
      end
    end
  endtask

  task automatic endTest(input string name);
    bit ok;
    int errNow;
    errNow = errCnt + monErr + dut0.checker0.failCnt;
    ok = (errNow == testErr) && !hung;
    testsRun++;
    if (!ok)
    begin
      testsBad++;
    end
    $display("test %0d %s: %s", testsRun, name, ok ? "ok" : "failed");
    testErr = errNow;
  endtask

  always @(posedge clk)
  begin
    mAxisTready <= !stallOut || ($urandom_range(3) != 0);
  end

  // input must stay closed from bit 1024 until the tlast beat
  always @(posedge clk)
  begin
    if (inClosed && !bitMatches("sAxisTready", 1'b0, sAxisTready))
    begin
      monErr++;
    end
    if (sAxisTvalid && sAxisTready)
    begin
      inCnt++;
      if (inCnt == K)
      begin
        inClosed = 1'b1;
        inCnt = 0;
      end
    end
    if (mAxisTvalid && mAxisTready)
    begin
      if (expQ.size() == 0)
      begin
        $display("output beat at %0t arrived with nothing expected", $time);
        monErr++;
      end
      else
      begin
        expBit = expQ.pop_front();
        if (!bitMatches("mAxisTdata", expBit, mAxisTdata))
        begin
          monErr++;
        end
      end
      if (!bitMatches("mAxisTlast", outBeat == N - 1, mAxisTlast))
      begin
        monErr++;
      end
      outBeat = (outBeat == N - 1) ? 0 : outBeat + 1;
      if (mAxisTlast)
      begin
        inClosed = 1'b0;
      end
    end
  end

  initial
  begin
    void'($urandom(32'hf91a));
    rst_n = 1'b0;
    sAxisTdata = 1'b0;
    sAxisTvalid = 1'b0;
    stallOut = 1'b0;
    hung = 1'b0;
    errCnt = 0;
    testErr = 0;
    testsRun = 0;
    testsBad = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    errCnt += int'(!bitMatches("sAxisTready", 1'b0, sAxisTready));
    errCnt += int'(!bitMatches("mAxisTvalid", 1'b0, mAxisTvalid));
    errCnt += int'(!bitMatches("mAxisTlast", 1'b0, mAxisTlast));
    endTest("reset state");

    expectFrame('0);
    sendFrame('0, 1'b0);
    drainOutput();
    endTest("all-zero frame");

    pos = $urandom_range(K - 1);
    oneHot = '0;
    oneHot[pos] = 1'b1;
    expectFrame(oneHot);
    sendFrame(oneHot, 1'b0);
    drainOutput();
    endTest($sformatf("single one at bit %0d", pos));

    for (int f = 0; f < 3; f++)
    begin
      for (int w = 0; w < K / 32; w++)
      begin
        frames[f][32*w +: 32] = $urandom();
      end
      expectFrame(frames[f]);
    end
    for (int f = 0; f < 3; f++)
    begin
      sendFrame(frames[f], 1'b0);
    end
    drainOutput();
    endTest("three random frames back to back");

    stallOut <= 1'b1;
    for (int f = 0; f < 3; f++)
    begin
      expectFrame(frames[f]);
    end
    for (int f = 0; f < 3; f++)
    begin
      sendFrame(frames[f], 1'b1);
    end
    drainOutput();
    stallOut <= 1'b0;
    endTest("random frames with gaps and stalls");

    errCnt += monErr + dut0.checker0.failCnt;
    $display("tests %0d, failed %0d, errors %0d, protocol failures %0d",
             testsRun, testsBad, errCnt, dut0.checker0.failCnt);
    if (errCnt == 0 && testsBad == 0 && !hung)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ldpc.f */
hdl/ldpcCodePkg.sv
hdl/ldpcFramePkg.sv
hdl/encStepIf.sv
hdl/ldpcInputSequencer.sv
hdl/ldpcParityLane.sv
hdl/ldpcOutputStage.sv
hdl/ldpcEncoder.sv
bench/ldpcEncoder_checker.sv
bench/ldpcEncoder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the LDPC encoder testbench with Verilator, run it, and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  --top-module ldpcEncoder_tb \
  -f ldpc.f \
  --Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/simv" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG_FILE"; then
  exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
